// File: logic/disk_pkg.sv
/*
	Shared sizes, constants and packed types of the disk sector bridge
	CPU word union, control levels, block request, host buffer port,
	status byte and mount record
*/
package disk_pkg;

	// ==============================
	// Sizes
	// ==============================
	localparam int SECTOR_BYTES = 512;
	localparam int BUF_AW       = 9;
	localparam int NUM_DRIVES   = 8;
	localparam int DRV_W        = 3;
	localparam int LBA_W        = 32;

	// Drives 4 and 5 are always mounted read-only
	localparam logic [NUM_DRIVES-1:0] RO_DRIVE_MASK = 8'b0011_0000;

	// Host link FSM encoding
	localparam logic [1:0] HL_IDLE   = 2'd0;
	localparam logic [1:0] HL_STROBE = 2'd1;
	localparam logic [1:0] HL_ACK    = 2'd2;

	// ==============================
	// CPU word
	// ==============================
	typedef struct packed {
		logic [23:0] pad;
		logic [7:0]  data;
	} byte_view_t;

	// Same 32-bit word seen either as a block address or as a data byte
	typedef union packed {
		logic [LBA_W-1:0] lba;
		byte_view_t       bytes;
	} cpu_word_u;

	// Control levels from the helper CPU
	typedef struct packed {
		logic             lba_sel;
		logic             block_rd;
		logic             block_wr;
		logic [DRV_W-1:0] drv_num;
		logic             io_wr;
		logic             data_wr;
		logic             data_rd;
	} cpu_ctrl_t;

	// ==============================
	// Transfers and status
	// ==============================
	typedef struct packed {
		logic             write;
		logic [DRV_W-1:0] drive;
		logic [LBA_W-1:0] lba;
	} block_req_t;

	typedef struct packed {
		logic [BUF_AW-1:0] addr;
		logic [7:0]        data;
		logic              wr;
	} host_buf_t;

	// Bit 7 down to bit 0 as seen by the CPU
	typedef struct packed {
		logic       readonly;
		logic [1:0] filetype;
		logic [2:0] fileno;
		logic       mounted;
		logic       io_done;
	} disk_status_t;

	typedef struct packed {
		logic [DRV_W-1:0] fileno;
		logic [1:0]       filetype;
		logic             readonly;
		logic             mounted;
		logic [LBA_W-1:0] size;
	} mount_info_t;

endpackage

// File: logic/cpu_port.sv
`timescale 1ns/1ps
/*
	CPU side of the disk bridge
	Edge detection on the control levels, block address register,
	shared buffer pointer, CPU read select and block request producer
*/
module cpu_port
	import disk_pkg::*;
(
	input  logic              clk_sys,
	input  logic              areset,
	input  cpu_ctrl_t         cpu_ctrl_i,
	input  cpu_word_u         cpu_wdata_i,
	input  logic [LBA_W-1:0]  file_size_i,
	input  logic [7:0]        buf_q_i,
	output logic [BUF_AW-1:0] buf_addr_o,
	output logic [7:0]        buf_data_o,
	output logic              buf_wr_o,
	output cpu_word_u         cpu_rdata_o,
	output block_req_t        req_o,
	output logic              req_valid_o,
	input  logic              req_ready_i
);

	logic [BUF_AW-1:0] ptr;
	logic              wr_d1;
	logic              wr_d2;
	logic              rd_d1;
	logic              blrd_d1;
	logic              blwr_d1;
	logic              buf_wr;
	logic [7:0]        wbyte;
	logic [LBA_W-1:0]  lba_q;
	logic              wr_edge;
	logic              rd_fall;
	logic              blk_edge;

	// ==============================
	// Edge detection
	// ==============================
	// Data write edge is taken one stage late, so the write lands 2 cycles after it
	assign wr_edge  = wr_d1 & ~wr_d2;
	assign rd_fall  = rd_d1 & ~cpu_ctrl_i.data_rd;
	assign blk_edge = (cpu_ctrl_i.block_rd & ~blrd_d1) | (cpu_ctrl_i.block_wr & ~blwr_d1);

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			wr_d1   <= 1'b0;
			wr_d2   <= 1'b0;
			rd_d1   <= 1'b0;
			blrd_d1 <= 1'b0;
			blwr_d1 <= 1'b0;
		end else begin
			wr_d1   <= cpu_ctrl_i.data_wr;
			wr_d2   <= wr_d1;
			rd_d1   <= cpu_ctrl_i.data_rd;
			blrd_d1 <= cpu_ctrl_i.block_rd;
			blwr_d1 <= cpu_ctrl_i.block_wr;
		end
	end

	// ==============================
	// Buffer pointer and writes
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			ptr    <= '0;
			buf_wr <= 1'b0;
		end else begin
			buf_wr <= wr_edge & ~cpu_ctrl_i.lba_sel;
			// Step after a buffer write or at the end of a read
			if (buf_wr || rd_fall)
				ptr <= ptr + 1'b1;
			if (cpu_ctrl_i.io_wr)
				ptr <= '0;
		end
	end

	// Same write word decoded as address or byte
	always_ff @(posedge clk_sys) begin
		if (wr_edge) begin
			if (cpu_ctrl_i.lba_sel)
				lba_q <= cpu_wdata_i.lba;
			else
				wbyte <= cpu_wdata_i.bytes.data;
		end
	end

	assign buf_addr_o = ptr;
	assign buf_data_o = wbyte;
	assign buf_wr_o   = buf_wr;

	// ==============================
	// Block request producer
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			req_valid_o <= 1'b0;
		end else if (req_valid_o) begin
			if (req_ready_i)
				req_valid_o <= 1'b0;
		end else if (blk_edge) begin
			req_valid_o <= 1'b1;
		end
	end

	// New block edges are dropped while a request is pending
	always_ff @(posedge clk_sys) begin
		if (!req_valid_o && blk_edge) begin
			req_o.write <= cpu_ctrl_i.block_wr & ~blwr_d1;
			req_o.drive <= cpu_ctrl_i.drv_num;
			req_o.lba   <= lba_q;
		end
	end

	// Read word carries the file size when lba_sel is high and the buffer byte otherwise
	always_comb begin
		cpu_rdata_o = '0;
		if (cpu_ctrl_i.lba_sel)
			cpu_rdata_o.lba = file_size_i;
		else
			cpu_rdata_o.bytes.data = buf_q_i;
	end

endmodule

// File: logic/sector_buffer.sv
`timescale 1ns/1ps
/*
	True dual-port sector RAM, 512 by 8
	Port A for the host, port B for the CPU, both with registered reads
*/
module sector_buffer
	import disk_pkg::*;
(
	input  logic              clk_sys,
	input  host_buf_t         host_i,
	output logic [7:0]        host_q_o,
	input  logic [BUF_AW-1:0] cpu_addr_i,
	input  logic [7:0]        cpu_data_i,
	input  logic              cpu_wr_i,
	output logic [7:0]        cpu_q_o
);

	logic [7:0] mem [SECTOR_BYTES];

	// Host port
	always_ff @(posedge clk_sys) begin
		if (host_i.wr)
			mem[host_i.addr] <= host_i.data;
		host_q_o <= mem[host_i.addr];
	end

	// CPU port
	always_ff @(posedge clk_sys) begin
		if (cpu_wr_i)
			mem[cpu_addr_i] <= cpu_data_i;
		cpu_q_o <= mem[cpu_addr_i];
	end

endmodule

// File: logic/host_link.sv
`timescale 1ns/1ps
/*
	Block request consumer on the host side
	Idle, strobe and acknowledge FSM with per-drive read and write strobes
	and the completion flag
*/
module host_link
	import disk_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  areset,
	input  block_req_t            req_i,
	input  logic                  req_valid_i,
	output logic                  req_ready_o,
	input  logic [NUM_DRIVES-1:0] sd_ack_i,
	output logic [NUM_DRIVES-1:0] sd_rd_o,
	output logic [NUM_DRIVES-1:0] sd_wr_o,
	output logic [LBA_W-1:0]      lba_o,
	output logic                  io_done_o
);

	logic [1:0]            state;
	logic [NUM_DRIVES-1:0] drv_onehot;
	logic                  any_ack;

	assign req_ready_o = (state == HL_IDLE);
	assign drv_onehot  = NUM_DRIVES'(1) << req_i.drive;
	assign any_ack     = |sd_ack_i;

	// ==============================
	// Control FSM
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			state     <= HL_IDLE;
			sd_rd_o   <= '0;
			sd_wr_o   <= '0;
			io_done_o <= 1'b0;
		end else begin
			case (state)
				HL_IDLE: begin
					if (req_valid_i) begin
						io_done_o <= 1'b0;
						sd_rd_o   <= req_i.write ? '0 : drv_onehot;
						sd_wr_o   <= req_i.write ? drv_onehot : '0;
						state     <= HL_STROBE;
					end
				end
				HL_STROBE: begin
					// Host has picked up the request
					if (any_ack) begin
						sd_rd_o <= '0;
						sd_wr_o <= '0;
						state   <= HL_ACK;
					end
				end
				HL_ACK: begin
					if (!any_ack) begin
						io_done_o <= 1'b1;
						state     <= HL_IDLE;
					end
				end
				default: begin
					state <= HL_IDLE;
				end
			endcase
		end
	end

	// Block address for the host is held through the transfer
	always_ff @(posedge clk_sys) begin
		if (req_valid_i && req_ready_o)
			lba_o <= req_i.lba;
	end

endmodule

// File: logic/mount_tracker.sv
`timescale 1ns/1ps
/*
	Image mount tracking
	Highest mounted drive, file type, read-only rule, mount toggle and size
*/
module mount_tracker
	import disk_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  areset,
	input  logic [NUM_DRIVES-1:0] img_mounted_i,
	input  logic                  img_readonly_i,
	input  logic [1:0]            file_type_i,
	input  logic [LBA_W-1:0]      img_size_i,
	output mount_info_t           mount_o
);

	logic             any_d1;
	logic             mount_edge;
	logic [DRV_W-1:0] hi_drv;

	assign mount_edge = (|img_mounted_i) & ~any_d1;

	// Priority encoder where the highest drive wins
	always_comb begin
		hi_drv = '0;
		for (int i = 0; i < NUM_DRIVES; i++) begin
			if (img_mounted_i[i])
				hi_drv = DRV_W'(i);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			any_d1          <= 1'b0;
			mount_o.mounted <= 1'b0;
		end else begin
			any_d1 <= |img_mounted_i;
			if (mount_edge)
				mount_o.mounted <= ~mount_o.mounted;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (mount_edge) begin
			mount_o.fileno   <= hi_drv;
			mount_o.filetype <= file_type_i;
			mount_o.readonly <= img_readonly_i | (|(img_mounted_i & RO_DRIVE_MASK));
			mount_o.size     <= img_size_i;
		end
	end

endmodule

// File: logic/disk_bridge_top.sv
`timescale 1ns/1ps
/*
	Disk sector bridge top level
	CPU port, sector buffer, host link and mount tracker
*/
module disk_bridge_top
	import disk_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  areset,

	// Helper CPU side
	input  cpu_ctrl_t             cpu_ctrl_i,
	input  cpu_word_u             cpu_wdata_i,
	output cpu_word_u             cpu_rdata_o,
	output disk_status_t          cpu_status_o,

	// Host block storage side
	input  host_buf_t             host_i,
	output logic [7:0]            sd_buff_din_o,
	input  logic [NUM_DRIVES-1:0] sd_ack_i,
	output logic [NUM_DRIVES-1:0] sd_rd_o,
	output logic [NUM_DRIVES-1:0] sd_wr_o,
	output logic [LBA_W-1:0]      lba_o,

	// Image mount events
	input  logic [NUM_DRIVES-1:0] img_mounted_i,
	input  logic                  img_readonly_i,
	input  logic [1:0]            file_type_i,
	input  logic [LBA_W-1:0]      img_size_i
);

	logic [BUF_AW-1:0] buf_addr;
	logic [7:0]        buf_data;
	logic              buf_wr;
	logic [7:0]        buf_q;
	block_req_t        req;
	logic              req_valid;
	logic              req_ready;
	logic              io_done;
	mount_info_t       mount;

	cpu_port u_cpu_port (
		.clk_sys     (clk_sys),
		.areset      (areset),
		.cpu_ctrl_i  (cpu_ctrl_i),
		.cpu_wdata_i (cpu_wdata_i),
		.file_size_i (mount.size),
		.buf_q_i     (buf_q),
		.buf_addr_o  (buf_addr),
		.buf_data_o  (buf_data),
		.buf_wr_o    (buf_wr),
		.cpu_rdata_o (cpu_rdata_o),
		.req_o       (req),
		.req_valid_o (req_valid),
		.req_ready_i (req_ready)
	);

	sector_buffer u_sector_buffer (
		.clk_sys    (clk_sys),
		.host_i     (host_i),
		.host_q_o   (sd_buff_din_o),
		.cpu_addr_i (buf_addr),
		.cpu_data_i (buf_data),
		.cpu_wr_i   (buf_wr),
		.cpu_q_o    (buf_q)
	);

	host_link u_host_link (
		.clk_sys     (clk_sys),
		.areset      (areset),
		.req_i       (req),
		.req_valid_i (req_valid),
		.req_ready_o (req_ready),
		.sd_ack_i    (sd_ack_i),
		.sd_rd_o     (sd_rd_o),
		.sd_wr_o     (sd_wr_o),
		.lba_o       (lba_o),
		.io_done_o   (io_done)
	);

	mount_tracker u_mount_tracker (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.img_mounted_i  (img_mounted_i),
		.img_readonly_i (img_readonly_i),
		.file_type_i    (file_type_i),
		.img_size_i     (img_size_i),
		.mount_o        (mount)
	);

	// Status byte polled by the CPU
	assign cpu_status_o.readonly = mount.readonly;
	assign cpu_status_o.filetype = mount.filetype;
	assign cpu_status_o.fileno   = mount.fileno;
	assign cpu_status_o.mounted  = mount.mounted;
	assign cpu_status_o.io_done  = io_done;

endmodule

// File: test/tb_disk_bridge.sv
`timescale 1ns/1ps
/*
	Testbench for the disk sector bridge
	Clock and reset, LFSR stimulus, host model, reference model, checks and watchdog
*/
module tb_disk_bridge
	import disk_pkg::*;
;

	localparam logic [31:0] LFSR_SEED  = 32'h14c1_81f8;
	localparam logic [31:0] LFSR_TAPS  = 32'hD000_0001;
	localparam int          XFER_BYTES = 5 * SECTOR_BYTES;
	localparam int          WDOG_LIMIT = 20 * XFER_BYTES + 2000;
	localparam int          WAIT_LIMIT = 100;
	localparam int          MOUNT_RUNS = 8;

	logic                  clk_sys;
	logic                  areset;
	cpu_ctrl_t             cpu_ctrl;
	cpu_word_u             cpu_wdata;
	cpu_word_u             cpu_rdata;
	disk_status_t          cpu_status;
	host_buf_t             host;
	logic [7:0]            sd_buff_din;
	logic [NUM_DRIVES-1:0] sd_ack;
	logic [NUM_DRIVES-1:0] sd_rd;
	logic [NUM_DRIVES-1:0] sd_wr;
	logic [LBA_W-1:0]      lba;
	logic [NUM_DRIVES-1:0] img_mounted;
	logic                  img_readonly;
	logic [1:0]            file_type;
	logic [LBA_W-1:0]      img_size;

	// Reference model state
	logic [31:0]      lfsr_state;
	logic [7:0]       model_buf [SECTOR_BYTES];
	logic [LBA_W-1:0] exp_lba;
	logic             exp_mounted;

	disk_bridge_top DUT (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.cpu_ctrl_i     (cpu_ctrl),
		.cpu_wdata_i    (cpu_wdata),
		.cpu_rdata_o    (cpu_rdata),
		.cpu_status_o   (cpu_status),
		.host_i         (host),
		.sd_buff_din_o  (sd_buff_din),
		.sd_ack_i       (sd_ack),
		.sd_rd_o        (sd_rd),
		.sd_wr_o        (sd_wr),
		.lba_o          (lba),
		.img_mounted_i  (img_mounted),
		.img_readonly_i (img_readonly),
		.file_type_i    (file_type),
		.img_size_i     (img_size)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ==============================
	// Helpers
	// ==============================
	// Galois LFSR stepped once per returned bit
	function automatic logic [31:0] rand_bits(input int nbits);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < nbits; i++) begin
			val = {val[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
		end
		return val;
	endfunction

	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	task automatic clear_pointer();
		cpu_ctrl.io_wr = 1'b1;
		tick();
		tick();
		cpu_ctrl.io_wr = 1'b0;
		tick();
		tick();
	endtask

	task automatic write_word(input logic sel_lba, input cpu_word_u word);
		cpu_ctrl.lba_sel = sel_lba;
		cpu_wdata = word;
		cpu_ctrl.data_wr = 1'b1;
		tick();
		tick();
		cpu_ctrl.data_wr = 1'b0;
		tick();
		tick();
		cpu_ctrl.lba_sel = 1'b0;
	endtask

	// Sample the byte at the pointer, then step the pointer with a data_rd pulse
	task automatic read_byte(output logic [7:0] b);
		b = cpu_rdata.bytes.data;
		cpu_ctrl.data_rd = 1'b1;
		tick();
		tick();
		cpu_ctrl.data_rd = 1'b0;
		tick();
		tick();
	endtask

	task automatic block_strobe(input logic is_write, input logic [DRV_W-1:0] drive);
		cpu_ctrl.drv_num  = drive;
		cpu_ctrl.block_wr = is_write;
		cpu_ctrl.block_rd = ~is_write;
		tick();
		tick();
		cpu_ctrl.block_wr = 1'b0;
		cpu_ctrl.block_rd = 1'b0;
		tick();
	endtask

	// Host side of one block transfer from strobe to completion
	task automatic serve_host(input logic is_write, input logic [DRV_W-1:0] drive);
		logic [NUM_DRIVES-1:0] onehot;
		logic [7:0]            b;
		int                    waited;
		onehot = NUM_DRIVES'(1) << drive;
		waited = 0;
		while ((sd_rd | sd_wr) == '0) begin
			if (waited == WAIT_LIMIT)
				abort_run("No block strobe came from the host link");
			tick();
			waited++;
		end
		check_value("sd_wr_o", sd_wr, is_write ? onehot : 8'h00);
		check_value("sd_rd_o", sd_rd, is_write ? 8'h00 : onehot);
		check_value("lba_o", lba, exp_lba);
		check_value("io_done", cpu_status.io_done, 1'b0);
		sd_ack = onehot;
		tick();
		check_value("sd_wr_o", sd_wr, 8'h00);
		check_value("sd_rd_o", sd_rd, 8'h00);
		for (int i = 0; i < SECTOR_BYTES; i++) begin
			host.addr = BUF_AW'(i);
			if (is_write) begin
				tick();
				check_value($sformatf("sd_buff_din_o[%0d]", i), sd_buff_din, model_buf[i]);
			end else begin
				b = rand_bits(8);
				model_buf[i] = b;
				host.data = b;
				host.wr = 1'b1;
				tick();
			end
		end
		host = '0;
		sd_ack = '0;
		waited = 0;
		while (!cpu_status.io_done) begin
			if (waited == WAIT_LIMIT)
				abort_run("io_done did not set after the acknowledge ended");
			tick();
			waited++;
		end
	endtask

	// Watchdog allows 20 cycles per transferred byte plus a margin
	initial begin
		repeat (WDOG_LIMIT) @(posedge clk_sys);
		abort_run("Watchdog expired before the tests finished");
	end

	// ==============================
	// Test sequence
	// ==============================
	initial begin
		cpu_word_u             word;
		logic [7:0]            b;
		logic [DRV_W-1:0]      drive;
		logic [DRV_W-1:0]      drive2;
		logic [NUM_DRIVES-1:0] pattern;
		logic [DRV_W-1:0]      hi;
		logic                  ro;

		lfsr_state   = LFSR_SEED;
		areset       = 1'b1;
		cpu_ctrl     = '0;
		cpu_wdata    = '0;
		host         = '0;
		sd_ack       = '0;
		img_mounted  = '0;
		img_readonly = 1'b0;
		file_type    = '0;
		img_size     = '0;
		exp_mounted  = 1'b0;
		repeat (5) @(posedge clk_sys);
		#1;
		areset = 1'b0;
		tick();

		// Idle state after reset
		check_value("sd_rd_o", sd_rd, 8'h00);
		check_value("sd_wr_o", sd_wr, 8'h00);
		check_value("io_done", cpu_status.io_done, 1'b0);
		check_value("mounted", cpu_status.mounted, 1'b0);

		// CPU fills the sector for a block write and the host reads it out
		clear_pointer();
		exp_lba = rand_bits(32);
		word.lba = exp_lba;
		write_word(1'b1, word);
		for (int i = 0; i < SECTOR_BYTES; i++) begin
			word.bytes.pad  = rand_bits(24);
			word.bytes.data = rand_bits(8);
			model_buf[i] = word.bytes.data;
			write_word(1'b0, word);
		end
		drive = rand_bits(3);
		block_strobe(1'b1, drive);
		serve_host(1'b1, drive);

		// Host fills the sector for a block read and the CPU reads it back
		exp_lba = rand_bits(32);
		word.lba = exp_lba;
		write_word(1'b1, word);
		drive = rand_bits(3);
		block_strobe(1'b0, drive);
		serve_host(1'b0, drive);
		clear_pointer();
		for (int i = 0; i < SECTOR_BYTES; i++) begin
			read_byte(b);
			check_value($sformatf("cpu_rdata_o[%0d]", i), b, model_buf[i]);
		end

		// Mount events
		for (int n = 0; n < MOUNT_RUNS; n++) begin
			pattern = rand_bits(8);
			// Odd runs stay off the read-only drives
			if (n % 2 == 1)
				pattern = pattern & 8'hcf;
			if (pattern == '0)
				pattern = 8'h01;
			img_mounted  = pattern;
			file_type    = rand_bits(2);
			img_readonly = rand_bits(1);
			img_size     = rand_bits(32);
			hi = '0;
			for (int d = NUM_DRIVES - 1; d >= 0; d--) begin
				if (pattern[d] && hi == '0)
					hi = DRV_W'(d);
			end
			ro = img_readonly | pattern[4] | pattern[5];
			exp_mounted = ~exp_mounted;
			tick();
			tick();
			img_mounted = '0;
			tick();
			check_value("fileno", cpu_status.fileno, hi);
			check_value("filetype", cpu_status.filetype, file_type);
			check_value("readonly", cpu_status.readonly, ro);
			check_value("mounted", cpu_status.mounted, exp_mounted);
			cpu_ctrl.lba_sel = 1'b1;
			tick();
			check_value("cpu_rdata_o", cpu_rdata.lba, img_size);
			cpu_ctrl.lba_sel = 1'b0;
			tick();
		end

		// Second block edge lands while the first request is still pending
		drive  = rand_bits(3);
		drive2 = drive + 3'd1 + DRV_W'(rand_bits(2));
		cpu_ctrl.drv_num  = drive;
		cpu_ctrl.block_wr = 1'b1;
		tick();
		cpu_ctrl.drv_num  = drive2;
		cpu_ctrl.block_rd = 1'b1;
		tick();
		tick();
		cpu_ctrl.block_wr = 1'b0;
		cpu_ctrl.block_rd = 1'b0;
		serve_host(1'b1, drive);
		repeat (30) begin
			tick();
			check_value("sd_rd_o", sd_rd, 8'h00);
			check_value("sd_wr_o", sd_wr, 8'h00);
			check_value("io_done", cpu_status.io_done, 1'b1);
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule

// File: sim.f
logic/disk_pkg.sv
logic/cpu_port.sv
logic/sector_buffer.sv
logic/host_link.sv
logic/mount_tracker.sv
logic/disk_bridge_top.sv
test/tb_disk_bridge.sv
